// ==== project.f ====
hdl/pkt_router_pkg.sv
hdl/ing_pkt_parser.sv
hdl/pkt_frame_buffer.sv
hdl/egr_hdr_rewriter.sv
hdl/pkt_router_top.sv
+incdir+dv
dv/pkt_router_tb.sv

// ==== Makefile ====
# Verilator flow for the packet reflection testbench

TOP := pkt_router_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

# the run passes only if the testbench printed its pass line
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== dv/pkt_router_model.svh ====
//////////////////////////////////////////////////////////////////////
// reference model for the reflection path, LFSR and expected frames
//////////////////////////////////////////////////////////////////////

`ifndef PKT_ROUTER_MODEL_SVH
`define PKT_ROUTER_MODEL_SVH

// 32 bit fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// n random bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v      = {v[30:0], lfsr_q[0]};
    end
    return v;
endfunction

// address filter first, then the runt limit
// truncation never drops a frame
function automatic bit frame_accepted(input logic [47:0] dst, input int len);
    bit addr_ok;
    addr_ok = (dst == LOCAL_MAC) || (dst == BCAST_MAC);
    return addr_ok && (len >= MIN_PKT_SIZE);
endfunction

// long frames are cut at the size limit
function automatic int out_length(input int len);
    return (len > MAX_PKT_SIZE) ? MAX_PKT_SIZE : len;
endfunction

// queue the reflected frame as {last, data}
// new destination is the old source, new source is the local MAC
function automatic void push_expected(input int f);
    int         n;
    int         i;
    logic [7:0] b;
    n = out_length(frame_len[f]);
    for (i = 0; i < n; i++) begin
        if (i < 6) begin
            b = frame_mem[f][i + 6];
        end else if (i < 12) begin
            // local MAC, msb byte first
            b = LOCAL_MAC[8 * (11 - i) +: 8];
        end else begin
            // EtherType and payload untouched
            b = frame_mem[f][i];
        end
        exp_q.push_back({(i == n - 1), b});
    end
endfunction

`endif

// ==== dv/pkt_router_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the reflection path, random frames against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pkt_router_tb;

    localparam int          MAX_PKT_SIZE = 100;
    localparam int          MIN_PKT_SIZE = 60;
    localparam int          BUF_DEPTH    = 256;
    localparam logic [47:0] LOCAL_MAC    = 48'hAABBCCDDEEFF;
    localparam logic [47:0] BCAST_MAC    = 48'hFFFF_FFFF_FFFF;

    // run shape
    localparam int NUM_FRAMES      = 200;
    localparam int BURST_FIRST     = 160;
    localparam int MIN_GEN_LEN     = 40;
    localparam int MAX_GEN_LEN     = 130;
    localparam int BURST_HOLD      = 800;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_GEN_LEN * 4;

    logic        core_clk_ifc;
    logic        rst_n;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_last;
    logic        in_ready;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_last;
    logic        out_ready;
    logic [15:0] drop_count;
    logic [15:0] fwd_count;

    // generated frames and the expected output stream
    logic [7:0]  frame_mem [NUM_FRAMES][MAX_GEN_LEN];
    int          frame_len [NUM_FRAMES];
    logic [8:0]  exp_q [$];
    logic [31:0] lfsr_q;

    int          frm_idx;
    int          exp_frames;
    int          exp_drops;
    int          out_frames;
    int          out_byte_idx;
    int          data_errs;
    int          count_errs;
    int          proto_errs;
    int          hold_cycles;
    int          stall_cycles;
    bit          burst_on;
    bit          ready_seen;
    bit          held_valid;
    logic [7:0]  held_data;
    logic        stall_pick;
    logic [8:0]  want;

    `include "pkt_router_model.svh"

    pkt_router_top #(
        .MAX_PKT_SIZE ( MAX_PKT_SIZE ),
        .MIN_PKT_SIZE ( MIN_PKT_SIZE ),
        .BUF_DEPTH    ( BUF_DEPTH    ),
        .LOCAL_MAC    ( LOCAL_MAC    )
    ) u_dut (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .in_data      ( in_data      ),
        .in_valid     ( in_valid     ),
        .in_last      ( in_last      ),
        .in_ready     ( in_ready     ),
        .out_data     ( out_data     ),
        .out_valid    ( out_valid    ),
        .out_last     ( out_last     ),
        .out_ready    ( out_ready    ),
        .drop_count   ( drop_count   ),
        .fwd_count    ( fwd_count    )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #4 core_clk_ifc = ~core_clk_ifc;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // random frame, burst frames always pass the filter and runt limit
    function automatic void gen_frame(input int f, input bit burst);
        logic [47:0] dst;
        logic [1:0]  pick;
        int          len;
        int          i;
        pick = 2'(rand_bits(2));
        if (burst) begin
            pick[1] = 1'b0;
        end
        case (pick)
            2'd0:    dst = LOCAL_MAC;
            2'd1:    dst = BCAST_MAC;
            default: dst = {16'(rand_bits(16)), rand_bits(32)};
        endcase
        if (burst) begin
            len = MIN_PKT_SIZE + int'(rand_bits(7) % 32'd71);
        end else begin
            len = MIN_GEN_LEN + int'(rand_bits(7) % 32'd91);
        end
        frame_len[f] = len;
        for (i = 0; i < len; i++) begin
            if (i < 6) begin
                frame_mem[f][i] = dst[8 * (5 - i) +: 8];
            end else begin
                frame_mem[f][i] = 8'(rand_bits(8));
            end
        end
        if (frame_accepted(dst, len)) begin
            push_expected(f);
            exp_frames++;
        end else begin
            exp_drops++;
        end
    endfunction

    // returns on the negedge before the edge that takes the byte
    task automatic send_byte(input logic [7:0] b, input logic last);
        @(posedge core_clk_ifc);
        // idle cycle before about one byte in four, none in the burst
        if (!burst_on && rand_bits(2) == 32'd0) begin
            in_valid <= 1'b0;
            in_last  <= 1'b0;
            @(posedge core_clk_ifc);
        end
        in_valid <= 1'b1;
        in_data  <= b;
        in_last  <= last;
        @(negedge core_clk_ifc);
        while (!in_ready) begin
            @(negedge core_clk_ifc);
        end
    endtask

    task automatic send_frame(input int f);
        int i;
        if (f == BURST_FIRST) begin
            // output held off so the buffer has to fill up
            burst_on    = 1'b1;
            hold_cycles = BURST_HOLD;
        end
        for (i = 0; i < frame_len[f]; i++) begin
            send_byte(frame_mem[f][i], (i == frame_len[f] - 1));
        end
    endtask

    // state right after reset release and one cycle later
    task automatic check_reset_state();
        @(negedge core_clk_ifc);
        if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
            $display("CHECK FAILED @%0t: in_ready %b out_valid %b after reset, expected 0",
                     $time, in_ready, out_valid);
            proto_errs++;
        end
        if (drop_count !== 16'd0 || fwd_count !== 16'd0) begin
            $display("CHECK FAILED @%0t: counters %0d/%0d after reset, expected 0",
                     $time, drop_count, fwd_count);
            count_errs++;
        end
        @(negedge core_clk_ifc);
        if (in_ready !== 1'b1) begin
            $display("CHECK FAILED @%0t: in_ready %b one cycle after reset, expected 1",
                     $time, in_ready);
            proto_errs++;
        end
    endtask

    // out_ready, random stalls plus one long hold at the burst
    initial begin
        @(posedge rst_n);
        forever begin
            @(negedge core_clk_ifc);
            stall_pick = (rand_bits(2) != 32'd0);
            @(posedge core_clk_ifc);
            if (hold_cycles > 0) begin
                out_ready   <= 1'b0;
                hold_cycles = hold_cycles - 1;
            end else begin
                out_ready <= stall_pick;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // monitor and scoreboard
    //////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge core_clk_ifc);
            if (rst_n === 1'b1) begin
                // back-pressure seen on the input side
                if (in_ready === 1'b1) begin
                    ready_seen = 1'b1;
                end else if (ready_seen) begin
                    stall_cycles++;
                end
                if (held_valid && (out_valid !== 1'b1 || out_data !== held_data)) begin
                    $display("CHECK FAILED @%0t: output byte %02h changed to %02h under stall",
                             $time, held_data, out_data);
                    proto_errs++;
                end
                held_valid = out_valid && !out_ready;
                held_data  = out_data;
                if (out_valid && out_ready) begin
                    if (exp_q.size() == 0) begin
                        $display("ERROR @%0t: output byte %02h arrived with no frame expected",
                                 $time, out_data);
                        data_errs++;
                    end else begin
                        want = exp_q.pop_front();
                        if (out_data !== want[7:0] || out_last !== want[8]) begin
                            $display(
                                "CHECK FAILED @%0t: frame %0d byte %0d got %02h/%b exp %02h/%b",
                                $time, out_frames, out_byte_idx, out_data, out_last,
                                want[7:0], want[8]);
                            data_errs++;
                        end
                    end
                    out_byte_idx++;
                    if (out_last) begin
                        out_frames++;
                        out_byte_idx = 0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        in_data   = 8'h00;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        lfsr_q    = 32'h859c712b;
        // all frames and their expected images up front
        for (frm_idx = 0; frm_idx < NUM_FRAMES; frm_idx++) begin
            gen_frame(frm_idx, frm_idx >= BURST_FIRST);
        end
        repeat (3) @(posedge core_clk_ifc);
        rst_n <= 1'b1;
        check_reset_state();
        for (frm_idx = 0; frm_idx < NUM_FRAMES; frm_idx++) begin
            send_frame(frm_idx);
        end
        @(posedge core_clk_ifc);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
        // drain, then a quiet stretch to catch extra bytes
        while (exp_q.size() != 0) begin
            @(negedge core_clk_ifc);
        end
        repeat (50) @(negedge core_clk_ifc);
        if (out_frames != exp_frames || fwd_count !== 16'(out_frames)) begin
            $display("CHECK FAILED @%0t: %0d frames out, fwd_count %0d, model %0d",
                     $time, out_frames, fwd_count, exp_frames);
            count_errs++;
        end
        if (drop_count !== 16'(exp_drops)) begin
            $display("CHECK FAILED @%0t: drop_count %0d, model %0d",
                     $time, drop_count, exp_drops);
            count_errs++;
        end
        if (stall_cycles == 0) begin
            $display("ERROR: in_ready never went low, the buffer never filled");
            proto_errs++;
        end
        $display("errors: data %0d, counters %0d, protocol %0d (%0d frames, %0d dropped)",
                 data_errs, count_errs, proto_errs, out_frames, exp_drops);
        if (data_errs + count_errs + proto_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // bounded by the worst case frame count times length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk_ifc);
        $display("TIMEOUT: run did not finish in %0d cycles, %0d bytes still expected",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : pkt_router_tb

`default_nettype wire

// ==== hdl/pkt_router_top.sv ====
//////////////////////////////////////////////////////////////////////
// single port reflection path, parser into frame buffer into rewriter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pkt_router_top #(
    parameter int          MAX_PKT_SIZE = 100,
    parameter int          MIN_PKT_SIZE = 60,
    parameter int          BUF_DEPTH    = 256,
    parameter logic [47:0] LOCAL_MAC    = 48'hAABBCCDDEEFF
) (
    input  logic        core_clk_ifc,
    input  logic        rst_n,
    input  logic [7:0]  in_data,
    input  logic        in_valid,
    input  logic        in_last,
    output logic        in_ready,
    output logic [7:0]  out_data,
    output logic        out_valid,
    output logic        out_last,
    input  logic        out_ready,
    output logic [15:0] drop_count,
    output logic [15:0] fwd_count
);
    import pkt_router_pkg::*;

    // parser to buffer
    logic       wr_en;
    logic [7:0] wr_data;
    logic       wr_last;
    buf_op_e    frame_op;
    logic       buf_full;

    // buffer to rewriter
    logic       rd_en;
    logic [7:0] rd_data;
    logic       rd_last;
    logic       rd_valid;

    ing_pkt_parser #(
        .MAX_PKT_SIZE ( MAX_PKT_SIZE ),
        .MIN_PKT_SIZE ( MIN_PKT_SIZE ),
        .LOCAL_MAC    ( LOCAL_MAC    )
    ) u_parser (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .in_data      ( in_data      ),
        .in_valid     ( in_valid     ),
        .in_last      ( in_last      ),
        .in_ready     ( in_ready     ),
        .wr_en        ( wr_en        ),
        .wr_data      ( wr_data      ),
        .wr_last      ( wr_last      ),
        .frame_op     ( frame_op     ),
        .buf_full     ( buf_full     ),
        .drop_count   ( drop_count   )
    );

    pkt_frame_buffer #(
        .BUF_DEPTH    ( BUF_DEPTH    ),
        .MAX_PKT_SIZE ( MAX_PKT_SIZE )
    ) u_buffer (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .wr_en        ( wr_en        ),
        .wr_data      ( wr_data      ),
        .wr_last      ( wr_last      ),
        .frame_op     ( frame_op     ),
        .buf_full     ( buf_full     ),
        .rd_en        ( rd_en        ),
        .rd_data      ( rd_data      ),
        .rd_last      ( rd_last      ),
        .rd_valid     ( rd_valid     )
    );

    egr_hdr_rewriter #(
        .LOCAL_MAC    ( LOCAL_MAC    )
    ) u_rewriter (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .rd_data      ( rd_data      ),
        .rd_last      ( rd_last      ),
        .rd_valid     ( rd_valid     ),
        .rd_en        ( rd_en        ),
        .out_data     ( out_data     ),
        .out_valid    ( out_valid    ),
        .out_last     ( out_last     ),
        .out_ready    ( out_ready    ),
        .fwd_count    ( fwd_count    )
    );

endmodule : pkt_router_top

`default_nettype wire

// ==== hdl/egr_hdr_rewriter.sv ====
//////////////////////////////////////////////////////////////////////
// egress header rewrite, source becomes destination, local MAC as source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module egr_hdr_rewriter #(
    parameter logic [47:0] LOCAL_MAC = 48'hAABBCCDDEEFF
) (
    input  logic        core_clk_ifc,
    input  logic        rst_n,
    input  logic [7:0]  rd_data,
    input  logic        rd_last,
    input  logic        rd_valid,
    output logic        rd_en,
    output logic [7:0]  out_data,
    output logic        out_valid,
    output logic        out_last,
    input  logic        out_ready,
    output logic [15:0] fwd_count
);
    import pkt_router_pkg::*;

    // both addresses, EtherType goes straight through
    localparam logic [3:0] HOLD_LAST = 4'(ETH_HDR_BYTES - 3);
    localparam logic [3:0] MAC_LAST  = 4'(MAC_BYTES - 1);

    rewrite_state_e state;
    logic [3:0]     idx;
    // header shifter, msb byte goes out first
    logic [47:0]    hdr_q;
    logic           out_xfer;

    assign out_xfer = out_valid & out_ready;

    //////////////////////////////////////////////////////////////////////
    // stream out
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_en     = 1'b0;
        out_data  = 8'h00;
        out_valid = 1'b0;
        out_last  = 1'b0;
        case (state)
            // swallow the original addresses
            RS_IDLE: rd_en = rd_valid;
            RS_DST, RS_SRC: begin
                out_data  = hdr_q[47:40];
                out_valid = 1'b1;
            end
            default: begin
                out_data  = rd_data;
                out_valid = rd_valid;
                out_last  = rd_last;
                rd_en     = rd_valid & out_ready;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // rewrite FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RS_IDLE;
            idx       <= '0;
            fwd_count <= '0;
        end else begin
            case (state)
                RS_IDLE: begin
                    if (rd_valid) begin
                        idx <= idx + 1'b1;
                        if (idx == HOLD_LAST) begin
                            idx   <= '0;
                            state <= RS_DST;
                        end
                    end
                end
                RS_DST: begin
                    if (out_ready) begin
                        idx <= idx + 1'b1;
                        if (idx == MAC_LAST) begin
                            idx   <= '0;
                            state <= RS_SRC;
                        end
                    end
                end
                RS_SRC: begin
                    if (out_ready) begin
                        idx <= idx + 1'b1;
                        if (idx == MAC_LAST) begin
                            idx   <= '0;
                            state <= RS_PASS;
                        end
                    end
                end
                default: begin
                    if (out_xfer && out_last) begin
                        state <= RS_IDLE;
                    end
                end
            endcase
            if (out_xfer && out_last) begin
                fwd_count <= fwd_count + 16'd1;
            end
        end
    end

    // all twelve header bytes shift through, the source MAC is what stays
    always_ff @(posedge core_clk_ifc) begin
        if (state == RS_IDLE && rd_valid) begin
            hdr_q <= {hdr_q[39:0], rd_data};
        end else if (state == RS_DST && out_ready && idx == MAC_LAST) begin
            hdr_q <= LOCAL_MAC;
        end else if (out_xfer) begin
            hdr_q <= {hdr_q[39:0], 8'h00};
        end
    end

    // held byte must not move under a stall
    a_out_stable: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule : egr_hdr_rewriter

`default_nettype wire

// ==== hdl/pkt_frame_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// frame buffer with commit / discard, frames visible once complete
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pkt_frame_buffer #(
    parameter int BUF_DEPTH    = 256,
    parameter int MAX_PKT_SIZE = 100
) (
    input  logic                    core_clk_ifc,
    input  logic                    rst_n,
    input  logic                    wr_en,
    input  logic [7:0]              wr_data,
    input  logic                    wr_last,
    input  pkt_router_pkg::buf_op_e frame_op,
    output logic                    buf_full,
    input  logic                    rd_en,
    output logic [7:0]              rd_data,
    output logic                    rd_last,
    output logic                    rd_valid
);
    import pkt_router_pkg::*;

    localparam int AW = $clog2(BUF_DEPTH);

    // a full size frame must fit or the parser stalls forever
    if (BUF_DEPTH < MAX_PKT_SIZE) begin : g_depth_chk
        $error("BUF_DEPTH must be at least MAX_PKT_SIZE");
    end

    // {last, data}
    logic [8:0]  mem [BUF_DEPTH];

    // pointers carry a wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] cmt_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] wr_nxt;
    logic [AW:0] fill;
    logic [AW:0] frm_cnt;
    logic        pop;
    logic        pop_last;
    logic        commit;

    assign wr_nxt   = wr_ptr + {{AW{1'b0}}, wr_en};
    assign commit   = (frame_op == OP_COMMIT);
    assign pop      = rd_en & rd_valid;
    assign pop_last = pop & rd_last;

    // speculative bytes count against space too
    assign fill     = wr_ptr - rd_ptr;
    assign buf_full = fill[AW];

    assign {rd_last, rd_data} = mem[rd_ptr[AW-1:0]];
    assign rd_valid = (frm_cnt != '0);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {wr_last, wr_data};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and frame count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
            rd_ptr  <= '0;
            frm_cnt <= '0;
        end else begin
            // discard rewinds to the last commit point
            if (frame_op == OP_DISCARD) begin
                wr_ptr <= cmt_ptr;
            end else begin
                wr_ptr <= wr_nxt;
            end
            // commit includes a byte written this cycle
            if (commit) begin
                cmt_ptr <= wr_nxt;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, pop_last})
                2'b10:   frm_cnt <= frm_cnt + 1'b1;
                2'b01:   frm_cnt <= frm_cnt - 1'b1;
                default: frm_cnt <= frm_cnt;
            endcase
        end
    end

    // reader only pops committed bytes
    a_pop_valid: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        rd_en |-> rd_valid);

endmodule : pkt_frame_buffer

`default_nettype wire

// ==== hdl/ing_pkt_parser.sv ====
//////////////////////////////////////////////////////////////////////
// ingress parser, destination MAC filter, truncation, runt discard
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ing_pkt_parser #(
    parameter int          MAX_PKT_SIZE = 100,
    parameter int          MIN_PKT_SIZE = 60,
    parameter logic [47:0] LOCAL_MAC    = 48'hAABBCCDDEEFF
) (
    input  logic                    core_clk_ifc,
    input  logic                    rst_n,
    input  logic [7:0]              in_data,
    input  logic                    in_valid,
    input  logic                    in_last,
    output logic                    in_ready,
    output logic                    wr_en,
    output logic [7:0]              wr_data,
    output logic                    wr_last,
    output pkt_router_pkg::buf_op_e frame_op,
    input  logic                    buf_full,
    output logic [15:0]             drop_count
);
    import pkt_router_pkg::*;

    localparam int CW = $clog2(MAX_PKT_SIZE + 1);
    // byte index of the last byte for a legal / truncated frame
    localparam logic [CW-1:0] MIN_LAST = CW'(MIN_PKT_SIZE - 1);
    localparam logic [CW-1:0] MAX_LAST = CW'(MAX_PKT_SIZE - 1);
    localparam logic [CW-1:0] DST_LAST = CW'(MAC_BYTES - 1);

    // a runt limit below the header would let headerless frames through
    if (MIN_PKT_SIZE < ETH_HDR_BYTES) begin : g_min_chk
        $error("MIN_PKT_SIZE must cover the ethernet header");
    end

    parser_state_e   state, nxt_state;
    logic [CW-1:0]   byte_cnt, nxt_cnt;
    logic [47:0]     dst_q;
    logic [47:0]     dst_nxt;
    logic            dst_hit;
    logic            rdy_q;
    logic            xfer;

    // ready comes up one cycle out of reset, then follows buffer space
    assign in_ready = rdy_q & ~buf_full;
    assign xfer     = in_valid & in_ready;
    assign wr_data  = in_data;

    // address as it stands with the current byte shifted in
    assign dst_nxt = {dst_q[39:0], in_data};
    assign dst_hit = (dst_nxt == LOCAL_MAC) || (dst_nxt == BROADCAST_MAC);

    //////////////////////////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nxt_state = state;
        nxt_cnt   = byte_cnt;
        wr_en     = 1'b0;
        wr_last   = 1'b0;
        frame_op  = OP_NONE;
        if (xfer) begin
            case (state)
                PS_DST: begin
                    nxt_cnt = byte_cnt + 1'b1;
                    if (in_last) begin
                        // too short to even hold an address
                        frame_op = OP_DISCARD;
                        nxt_cnt  = '0;
                    end else begin
                        wr_en = 1'b1;
                        if (byte_cnt == DST_LAST) begin
                            nxt_state = dst_hit ? PS_BODY : PS_DROP;
                        end
                    end
                end
                PS_BODY: begin
                    if (in_last && byte_cnt < MIN_LAST) begin
                        frame_op  = OP_DISCARD;
                        nxt_cnt   = '0;
                        nxt_state = PS_DST;
                    end else if (in_last || byte_cnt == MAX_LAST) begin
                        wr_en     = 1'b1;
                        wr_last   = 1'b1;
                        frame_op  = OP_COMMIT;
                        nxt_cnt   = '0;
                        // truncated frames swallow their tail
                        nxt_state = in_last ? PS_DST : PS_SKIP;
                    end else begin
                        wr_en   = 1'b1;
                        nxt_cnt = byte_cnt + 1'b1;
                    end
                end
                PS_SKIP: begin
                    if (in_last) begin
                        nxt_state = PS_DST;
                    end
                end
                default: begin
                    // filtered frame, nothing more is written
                    if (in_last) begin
                        frame_op  = OP_DISCARD;
                        nxt_cnt   = '0;
                        nxt_state = PS_DST;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state      <= PS_DST;
            byte_cnt   <= '0;
            rdy_q      <= 1'b0;
            drop_count <= '0;
        end else begin
            state    <= nxt_state;
            byte_cnt <= nxt_cnt;
            rdy_q    <= 1'b1;
            if (frame_op == OP_DISCARD) begin
                drop_count <= drop_count + 16'd1;
            end
        end
    end

    // address shifter, only meaningful during PS_DST
    always_ff @(posedge core_clk_ifc) begin
        if (xfer && state == PS_DST) begin
            dst_q <= dst_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // frames close only on an accepted last byte or at the size limit
    a_op_framing: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        (frame_op != OP_NONE) |-> (xfer && (in_last || byte_cnt == MAX_LAST)));

    // no write into a full buffer
    a_no_wr_full: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        wr_en |-> !buf_full);

endmodule : ing_pkt_parser

`default_nettype wire

// ==== hdl/pkt_router_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// packet reflection path shared definitions
// header sizes, broadcast address, FSM states and buffer opcodes
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pkt_router_pkg;

    // ethernet framing
    localparam int ETH_HDR_BYTES = 14;
    localparam int MAC_BYTES     = 6;

    localparam logic [47:0] BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

    // ingress parser states
    typedef enum logic [1:0] {
        PS_DST,
        PS_BODY,
        PS_SKIP,
        PS_DROP
    } parser_state_e;

    // egress rewriter states
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_DST,
        RS_SRC,
        RS_PASS
    } rewrite_state_e;

    // end of frame request from parser to buffer
    typedef enum logic [1:0] {
        OP_NONE,
        OP_COMMIT,
        OP_DISCARD
    } buf_op_e;

endpackage : pkt_router_pkg

`default_nettype wire
